// File: verilog/bch_pkg.sv
package bch_pkg;

	localparam int m_bits = 4;
	localparam int n_bits = 15;
	localparam int k_bits = 7;
	localparam int ecc_bits = 8;
	localparam int t_max = 2;
	localparam int err_sz = 2;
	localparam logic [4:0] prim_poly = 5'b10011; // x^4 + x + 1.
	localparam logic [8:0] gen_poly = 9'b111010001; // x^8 + x^7 + x^6 + x^4 + 1.
	localparam int stack_sz = 16;

	function automatic logic [m_bits-1:0] gf_mul(input logic [m_bits-1:0] a,
		input logic [m_bits-1:0] b);
		logic [m_bits-1:0] prod;
		logic [m_bits-1:0] x;
		prod = '0;
		x = a;
		for (int i = 0; i < m_bits; i++) begin
			if (b[i])
				prod = prod ^ x;
			x = x[m_bits-1] ? ((x << 1) ^ prim_poly[m_bits-1:0]) : (x << 1);
		end
		return prod;
	endfunction

	function automatic logic [m_bits-1:0] gf_inv(input logic [m_bits-1:0] a);
		logic [m_bits-1:0] inv_table [16];
		inv_table = '{4'd0, 4'd1, 4'd9, 4'd14, 4'd13, 4'd11, 4'd7, 4'd6,
			4'd15, 4'd2, 4'd12, 4'd5, 4'd10, 4'd4, 4'd3, 4'd8};
		return inv_table[a]; // zero maps to zero so a missing S1 gives no sigma2.
	endfunction

	function automatic logic [err_sz-1:0] bit_count(input logic [n_bits-1:0] bits);
		int count;
		count = 0;
		for (int i = 0; i < n_bits; i++) begin
			count = count + int'(bits[i]);
		end
		if (count > t_max)
			count = t_max; // the code cannot tell more errors apart.
		return err_sz'(count);
	endfunction

endpackage

// File: verilog/bch_encode.sv
`timescale 1ns/1ps

module bch_encode (
	input  logic clk,
	input  logic reset,
	input  logic ce,
	input  logic start,
	input  logic [bch_pkg::k_bits-1:0] data_in,
	output logic ready,
	output logic data_out,
	output logic first,
	output logic last
);
	import bch_pkg::*;

	logic active;
	logic [3:0] pos;
	logic [k_bits-1:0] msg_sr;
	logic [ecc_bits-1:0] lfsr;
	logic take;
	logic feed;

	assign first = active && (pos == 4'd0);
	assign last = active && (pos == n_bits - 1);
	assign ready = !active || last;
	assign take = start && ready;
	assign feed = msg_sr[k_bits-1] ^ lfsr[ecc_bits-1]; // divider feedback.

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			pos <= 4'd0;
		end else if (ce) begin
			if (take) begin
				active <= 1'b1;
				pos <= 4'd0;
			end else if (active) begin
				pos <= pos + 4'd1;
				if (last)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			if (take) begin
				data_out <= data_in[k_bits-1];
				msg_sr <= data_in << 1;
				lfsr <= data_in[k_bits-1] ? gen_poly[ecc_bits-1:0] : '0;
			end else if (active && (pos < k_bits - 1)) begin
				data_out <= msg_sr[k_bits-1];
				msg_sr <= msg_sr << 1;
				lfsr <= (lfsr << 1) ^ (feed ? gen_poly[ecc_bits-1:0] : '0);
			end else if (active) begin
				data_out <= lfsr[ecc_bits-1]; // remainder goes out msb first.
				lfsr <= lfsr << 1;
			end
		end
	end

endmodule

// File: verilog/bch_syndrome.sv
`timescale 1ns/1ps

module bch_syndrome (
	input  logic clk,
	input  logic reset,
	input  logic ce,
	input  logic start,
	input  logic data_in,
	output logic [2*bch_pkg::m_bits-1:0] syndromes,
	output logic done,
	input  logic ack
);
	import bch_pkg::*;

	logic active;
	logic [3:0] cnt;
	logic [m_bits-1:0] s1;
	logic [m_bits-1:0] s3;
	logic [m_bits-1:0] in_elem;

	assign in_elem = {{(m_bits-1){1'b0}}, data_in};
	assign syndromes = {s3, s1};

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			cnt <= 4'd0;
			done <= 1'b0;
		end else begin
			if (ce) begin
				if (start) begin
					active <= 1'b1;
					cnt <= 4'd1;
				end else if (active) begin
					cnt <= cnt + 4'd1;
					if (cnt == n_bits - 1) begin
						active <= 1'b0;
						done <= 1'b1; // fifteenth bit is in.
					end
				end
			end
			if (done && ack)
				done <= 1'b0;
		end
	end

	// Horner steps, highest coefficient first.
	always_ff @(posedge clk) begin
		if (ce) begin
			if (start) begin
				s1 <= in_elem;
				s3 <= in_elem;
			end else if (active) begin
				s1 <= gf_mul(s1, 4'b0010) ^ in_elem; // times alpha.
				s3 <= gf_mul(s3, 4'b1000) ^ in_elem; // times alpha cubed.
			end
		end
	end

endmodule

// File: verilog/bch_error_dec.sv
`timescale 1ns/1ps

module bch_error_dec (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [2*bch_pkg::m_bits-1:0] syndromes,
	output logic ready,
	output logic first,
	output logic valid,
	output logic last,
	output logic err,
	output logic [bch_pkg::err_sz-1:0] err_count,
	output logic errors_present
);
	import bch_pkg::*;

	logic take;
	logic sig_stage;
	logic load_stage;
	logic searching;
	logic [2:0] pos;

	logic [2*m_bits-1:0] syn_r;
	logic [m_bits-1:0] s1;
	logic [m_bits-1:0] s3;
	logic [m_bits-1:0] s1_cube;
	logic [m_bits-1:0] sig2_next;
	logic [err_sz-1:0] count_next;

	logic [m_bits-1:0] sigma1;
	logic [m_bits-1:0] sigma2;
	logic [err_sz-1:0] count_r;
	logic [m_bits-1:0] t1;
	logic [m_bits-1:0] t2;

	assign ready = !(sig_stage || load_stage || searching);
	assign take = start && ready;

	assign s1 = syn_r[m_bits-1:0];
	assign s3 = syn_r[2*m_bits-1:m_bits];
	assign s1_cube = gf_mul(s1, gf_mul(s1, s1));
	assign sig2_next = gf_mul(s3 ^ s1_cube, gf_inv(s1));

	// A single error at X gives S3 = X^3 = S1^3.
	always_comb begin
		if (syn_r == '0)
			count_next = err_sz'(0);
		else if (s3 == s1_cube)
			count_next = err_sz'(1);
		else
			count_next = err_sz'(2);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sig_stage <= 1'b0;
			load_stage <= 1'b0;
			searching <= 1'b0;
			pos <= 3'd0;
		end else begin
			sig_stage <= take;
			load_stage <= sig_stage;
			if (load_stage) begin
				searching <= 1'b1;
				pos <= 3'd0;
			end else if (searching) begin
				pos <= pos + 3'd1;
				if (pos == k_bits - 1)
					searching <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			syn_r <= syndromes;

		if (sig_stage) begin
			sigma1 <= s1;
			sigma2 <= sig2_next;
			count_r <= count_next;
		end

		// Position 14 is checked at alpha^-14 = alpha, then one step of alpha per cycle.
		if (load_stage) begin
			t1 <= gf_mul(sigma1, 4'b0010);
			t2 <= gf_mul(sigma2, 4'b0100);
		end else if (searching) begin
			t1 <= gf_mul(t1, 4'b0010);
			t2 <= gf_mul(t2, 4'b0100); // alpha squared for the quadratic term.
		end
	end

	assign first = searching && (pos == 3'd0);
	assign last = searching && (pos == k_bits - 1);
	assign valid = searching;
	assign err = searching && ((t1 ^ t2) == 4'b0001); // root of 1 + t1 + t2.
	assign err_count = count_r;
	assign errors_present = |syn_r;

endmodule

// File: verilog/bch_scoreboard.sv
`timescale 1ns/1ps

module bch_scoreboard (
	input  logic clk,
	input  logic reset,
	input  logic accept,
	input  logic [bch_pkg::n_bits-1:0] error,
	input  logic err_first,
	input  logic [bch_pkg::err_sz-1:0] err_count,
	input  logic errors_present,
	input  logic err_valid,
	input  logic err_last,
	input  logic err,
	output logic wrong
);
	import bch_pkg::*;

	logic [k_bits-1:0] mask_stack [stack_sz];
	logic [err_sz-1:0] count_stack [stack_sz];
	logic [stack_sz-1:0] present_stack;

	logic [$clog2(stack_sz)-1:0] wr_pos;
	logic [$clog2(stack_sz)-1:0] wr_next;
	logic [$clog2(stack_sz)-1:0] count_rd;
	logic [$clog2(stack_sz)-1:0] present_rd;
	logic [$clog2(stack_sz)-1:0] err_rd;

	logic [k_bits-1:0] err_buf;
	logic err_done;

	logic overflow;
	logic count_wrong;
	logic present_wrong;
	logic err_wrong;
	logic new_wrong;

	assign wr_next = wr_pos + 1'b1;

	// The stack counts as full one entry early so a write never lands on a live entry.
	assign overflow = (wr_next == count_rd) || (wr_next == present_rd) ||
		(wr_next == err_rd);
	assign count_wrong = err_first && (err_count != count_stack[count_rd]);
	assign present_wrong = err_first && (errors_present != present_stack[present_rd]);
	assign err_wrong = err_done && (err_buf != mask_stack[err_rd]);
	assign new_wrong = overflow || count_wrong || present_wrong || err_wrong;

	always_ff @(posedge clk) begin
		if (accept) begin
			mask_stack[wr_pos] <= error[n_bits-1 -: k_bits]; // data part only.
			count_stack[wr_pos] <= bit_count(error);
			present_stack[wr_pos] <= |error;
		end
	end

	// First flag ends up in bit k_bits-1 to line up with mask bit 14.
	always_ff @(posedge clk) begin
		if (err_first)
			err_buf <= {{(k_bits-1){1'b0}}, err};
		else if (err_valid)
			err_buf <= {err_buf[k_bits-2:0], err};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_pos <= '0;
			count_rd <= '0;
			present_rd <= '0;
			err_rd <= '0;
			err_done <= 1'b0;
			wrong <= 1'b0;
		end else begin
			if (accept)
				wr_pos <= wr_next;
			if (err_first) begin
				count_rd <= count_rd + 1'b1;
				present_rd <= present_rd + 1'b1;
			end
			err_done <= err_last;
			if (err_done)
				err_rd <= err_rd + 1'b1;
			if (new_wrong)
				wrong <= 1'b1; // sticky until reset.
		end
	end

endmodule

// File: verilog/bch_loopback.sv
`timescale 1ns/1ps

module bch_loopback (
	input  logic clk,
	input  logic reset,
	input  logic [bch_pkg::k_bits-1:0] data_in,
	input  logic [bch_pkg::n_bits-1:0] error,
	input  logic encode_start,
	output logic busy,
	output logic err_first,
	output logic err_valid,
	output logic err_last,
	output logic err,
	output logic [bch_pkg::err_sz-1:0] err_count,
	output logic errors_present,
	output logic wrong
);
	import bch_pkg::*;

	logic encode_ready;
	logic encoded_data;
	logic encoded_first;
	logic encoded_last;
	logic decoder_in;
	logic [2*m_bits-1:0] syndromes;
	logic syn_done;
	logic key_ready;
	logic ce;
	logic accept;
	logic [n_bits-1:0] mask_sr;

	assign ce = !(syn_done && !key_ready); // stall while syndromes wait for the locator.
	assign busy = !encode_ready || !ce;
	assign accept = encode_start && !busy;
	assign decoder_in = encoded_data ^ mask_sr[n_bits-1];

	// Mask bit 14 lines up with the first codeword bit.
	always_ff @(posedge clk) begin
		if (accept)
			mask_sr <= error;
		else if (ce)
			mask_sr <= {mask_sr[n_bits-2:0], 1'b0};
	end

	bch_encode u_encode (
		.clk(clk), .reset(reset), .ce(ce), .start(accept), .data_in(data_in),
		.ready(encode_ready), .data_out(encoded_data), .first(encoded_first),
		.last(encoded_last)
	);

	bch_syndrome u_syndrome (
		.clk(clk), .reset(reset), .ce(ce), .start(encoded_first), .data_in(decoder_in),
		.syndromes(syndromes), .done(syn_done), .ack(key_ready)
	);

	bch_error_dec u_error_dec (
		.clk(clk), .reset(reset), .start(syn_done), .syndromes(syndromes),
		.ready(key_ready), .first(err_first), .valid(err_valid), .last(err_last),
		.err(err), .err_count(err_count), .errors_present(errors_present)
	);

	bch_scoreboard u_scoreboard (
		.clk(clk), .reset(reset), .accept(accept), .error(error),
		.err_first(err_first), .err_count(err_count), .errors_present(errors_present),
		.err_valid(err_valid), .err_last(err_last), .err(err), .wrong(wrong)
	);

endmodule

// File: tb/bch_loopback_properties.sv
`timescale 1ns/1ps

module bch_loopback_properties (
	input logic clk,
	input logic reset,
	input logic accept,
	input logic busy,
	input logic encoded_first,
	input logic encoded_last,
	input logic syn_done,
	input logic key_ready,
	input logic err_first,
	input logic err_valid,
	input logic err_last,
	input logic wrong
);

	frame_length: assert property (@(posedge clk) disable iff (reset)
		err_first |-> ##6 (err_valid && err_last) ##1 !err_valid) // seven flag cycles.
		else $error("err_valid did not run exactly seven cycles from err_first");

	frame_gapless: assert property (@(posedge clk) disable iff (reset)
		(err_valid && !err_last) |=> err_valid)
		else $error("err_valid dropped before err_last");

	word_done: assert property (@(posedge clk) disable iff (reset)
		encoded_last |=> syn_done)
		else $error("syn_done did not follow the last codeword bit");

	syn_held: assert property (@(posedge clk) disable iff (reset)
		(syn_done && !key_ready) |=> syn_done)
		else $error("syn_done fell before the locator took the syndromes");

	busy_after_accept: assert property (@(posedge clk) disable iff (reset)
		accept |=> (encoded_first && busy))
		else $error("an accepted word did not start a codeword with busy high");

	never_wrong: assert property (@(posedge clk) disable iff (reset) !wrong)
		else $error("the scoreboard raised wrong");

endmodule

bind bch_loopback bch_loopback_properties u_properties (
	.clk(clk), .reset(reset), .accept(accept), .busy(busy),
	.encoded_first(encoded_first), .encoded_last(encoded_last), .syn_done(syn_done),
	.key_ready(key_ready), .err_first(err_first), .err_valid(err_valid),
	.err_last(err_last), .wrong(wrong)
);

// File: tb/bch_loopback_tb.sv
`timescale 1ns/1ps

module bch_loopback_tb;
	import bch_pkg::*;

	localparam int word_count = 40; // words in each test phase.
	localparam int reset_rounds = 4;
	localparam int reset_cycles = 5;
	localparam int total_words = 5 * word_count + 3 * reset_rounds;
	localparam int timeout_cycles = 30 * total_words + (reset_rounds + 1) * reset_cycles;

	logic clk;
	logic reset;
	logic [k_bits-1:0] data_in;
	logic [n_bits-1:0] error;
	logic encode_start;
	logic busy;
	logic err_first;
	logic err_valid;
	logic err_last;
	logic err;
	logic [err_sz-1:0] err_count;
	logic errors_present;
	logic wrong;

	integer seed = 32'hcf70_a9cd;
	logic [n_bits-1:0] exp_masks [$];
	logic [n_bits-1:0] cur_mask;
	logic [k_bits-1:0] got_flags;
	logic [err_sz-1:0] exp_count;

	bch_loopback u_bch_loopback (
		.clk(clk), .reset(reset), .data_in(data_in), .error(error),
		.encode_start(encode_start), .busy(busy), .err_first(err_first),
		.err_valid(err_valid), .err_last(err_last), .err(err), .err_count(err_count),
		.errors_present(errors_present), .wrong(wrong)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run;
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// more than two errors cannot be told apart, so the count saturates.
	function automatic logic [err_sz-1:0] weight_of(input logic [n_bits-1:0] mask);
		int w;
		w = 0;
		for (int i = 0; i < n_bits; i++) begin
			if (mask[i])
				w++;
		end
		return (w > 2) ? 2'd2 : err_sz'(w);
	endfunction

	function automatic logic [n_bits-1:0] random_mask(input int weight);
		int p1;
		int p2;
		logic [n_bits-1:0] mask;
		mask = '0;
		p1 = {$random(seed)} % n_bits;
		p2 = (p1 + 1 + {$random(seed)} % (n_bits - 1)) % n_bits; // never equal to p1.
		if (weight >= 1)
			mask[p1] = 1'b1;
		if (weight >= 2)
			mask[p2] = 1'b1;
		return mask;
	endfunction

	task automatic send_word(input logic [n_bits-1:0] mask);
		logic [31:0] rnd;
		rnd = $random(seed);
		data_in = rnd[k_bits-1:0];
		error = mask;
		encode_start = 1'b1;
		while (busy)
			@(negedge clk);
		exp_masks.push_back(mask); // the next rising edge is the accept.
		@(negedge clk);
		encode_start = 1'b0;
	endtask

	task automatic idle_random(input int max_gap);
		int gap;
		gap = {$random(seed)} % (max_gap + 1);
		repeat (gap) @(negedge clk);
	endtask

	task automatic apply_reset;
		reset = 1'b1;
		encode_start = 1'b0;
		exp_masks.delete();
		repeat (reset_cycles) @(negedge clk);
		assert ({err_first, err_valid, err_last, wrong, busy} == 5'b0) else begin
			$display("Error: time %0t {err_first,err_valid,err_last,wrong,busy} expected 00000 got %b",
				$time, {err_first, err_valid, err_last, wrong, busy});
			abort_run();
		end
		reset = 1'b0;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			got_flags = '0;
		end else begin
			assert (wrong == 1'b0) else begin
				$display("Error: time %0t wrong expected 0 got %0b", $time, wrong);
				abort_run();
			end
			if (err_first) begin
				assert (exp_masks.size() != 0) else begin
					$display("Error: time %0t a result arrived with no word pending", $time);
					abort_run();
				end
				cur_mask = exp_masks.pop_front();
				exp_count = weight_of(cur_mask);
				assert (err_count == exp_count) else begin
					$display("Error: time %0t err_count expected %0d got %0d",
						$time, exp_count, err_count);
					abort_run();
				end
				assert (errors_present == (|cur_mask)) else begin
					$display("Error: time %0t errors_present expected %0b got %0b",
						$time, |cur_mask, errors_present);
					abort_run();
				end
				got_flags = '0;
			end
			if (err_valid)
				got_flags = {got_flags[k_bits-2:0], err};
			if (err_last) begin
				assert (got_flags == cur_mask[n_bits-1 -: k_bits]) else begin
					$display("Error: time %0t err flags expected %b got %b",
						$time, cur_mask[n_bits-1 -: k_bits], got_flags);
					abort_run();
				end
			end
		end
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
		abort_run();
	end

	initial begin
		reset = 1'b1;
		encode_start = 1'b0;
		data_in = '0;
		error = '0;
		apply_reset();
		for (int i = 0; i < word_count; i++) begin
			send_word('0);
			idle_random(3);
		end
		for (int i = 0; i < word_count; i++) begin
			send_word(random_mask(1));
			idle_random(3);
		end
		for (int i = 0; i < word_count; i++) begin
			send_word(random_mask(2));
			idle_random(3);
		end
		for (int i = 0; i < word_count; i++) begin
			send_word(random_mask({$random(seed)} % 3)); // mostly back to back.
			idle_random(1);
		end
		for (int r = 0; r < reset_rounds; r++) begin
			for (int i = 0; i < 3; i++)
				send_word(random_mask({$random(seed)} % 3));
			idle_random(20);
			apply_reset(); // drops whatever is still in flight.
		end
		for (int i = 0; i < word_count; i++) begin
			send_word(random_mask({$random(seed)} % 3));
			idle_random(2);
		end
		while (exp_masks.size() != 0)
			@(negedge clk);
		repeat (40) @(negedge clk); // a stray result would still show up here.
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: list.f
verilog/bch_pkg.sv
verilog/bch_encode.sv
verilog/bch_syndrome.sv
verilog/bch_error_dec.sv
verilog/bch_scoreboard.sv
verilog/bch_loopback.sv
tb/bch_loopback_properties.sv
tb/bch_loopback_tb.sv

// File: run.sh
#!/bin/sh
# Build the loopback testbench with Verilator, run it and judge the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bch_loopback_tb \
	-f list.f -o bch_loopback_sim > build.log 2>&1 \
	&& ./obj_dir/bch_loopback_sim > sim.log 2>&1
cat build.log
test -f sim.log && cat sim.log
test -f sim.log || { echo "build failed"; exit 1; }
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
exit 0
